// ==== sources.f ====
+incdir+include
src/core_pkg.sv
src/settings_regs.sv
src/input_mapper.sv
src/dataslot_control.sv
src/video_formatter.sv
src/core_top.sv
testbench/core_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build core_top_tb with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module core_top_tb -f sources.f -o sim_core_top \
    && { ./obj_dir/sim_core_top > sim.log 2>&1 || true; } \
    || { echo "build failed"; exit 1; }

cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation PASSED"

// ==== testbench/core_top_tb.sv ====
//////////////////////////////////////////////////////////////////////
// self-checking testbench for core_top in the clk_74a domain
// a cycle model predicts every output
// outputs are compared on the falling edge
// rgb is compared only once a visible pixel has been seen
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_params.svh"

module core_top_tb;

    import core_pkg::*;

    logic           clk_74a;
    logic           pll_core_locked;
    bridge_wr_t     bridge;
    logic           reset_n;
    logic           dataslot_requestwrite;
    logic           dataslot_allcomplete;
    logic [31:0]    datatable_q;
    dt_port_t       datatable;
    logic [31:0]    rom_file_size;
    cont_key_t      cont1;
    cont_key_t      cont2;
    logic [7:0]     dip_switches;
    game_switches_t switches;
    logic           core_reset_n;
    game_video_t    game;
    scaler_video_t  scaler;

    // model state
    core_settings_t m_set;
    game_switches_t m_sw;
    logic           m_dl;
    logic [2:0]     m_div;
    dt_port_t       m_dt;
    logic [31:0]    m_rom;
    logic           m_pix_prev;
    logic           m_en;
    logic           m_hbl [`HBLANK_DELAY];
    logic           m_hs_prev;
    logic           m_vs_prev;
    scaler_video_t  m_vid;
    logic           m_rgb_valid;
    int             vk;

    logic [31:0]    lcg_state;
    string          test_name;
    int             vis_count;

    core_top uut (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .bridge                (bridge),
        .reset_n               (reset_n),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .datatable_q           (datatable_q),
        .datatable             (datatable),
        .rom_file_size         (rom_file_size),
        .cont1                 (cont1),
        .cont2                 (cont2),
        .dip_switches          (dip_switches),
        .switches              (switches),
        .core_reset_n          (core_reset_n),
        .game                  (game),
        .scaler                (scaler)
    );

    // 40 ns period
    initial begin
        clk_74a = 1'b0;
        forever #20 clk_74a = ~clk_74a;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // each setting pair puts its high bit on the lower index
    function automatic logic [7:0] dip_from(input core_settings_t s);
        logic [7:0] d;
        d[0] = s.difficulty[1];
        d[1] = s.difficulty[0];
        d[2] = s.first_bonus[1];
        d[3] = s.first_bonus[0];
        d[4] = s.next_bonus[1];
        d[5] = s.next_bonus[0];
        d[6] = s.players[1];
        d[7] = s.players[0];
        return d;
    endfunction

    // active-low switch bytes
    // right2 has no game input
    function automatic game_switches_t map_keys(input cont_key_t c1, input cont_key_t c2);
        game_switches_t s;
        s.sw1[7] = 1'b1;
        s.sw1[6] = ~c2.face_start;
        s.sw1[5] = ~c1.face_start;
        s.sw1[4] = ~c1.face_a;
        s.sw1[3] = ~c1.dpad_down;
        s.sw1[2] = ~c1.dpad_up;
        s.sw1[1] = ~c1.dpad_left;
        s.sw1[0] = ~c1.dpad_right;
        s.sw2[7] = 1'b1;
        s.sw2[6] = 1'b1;
        s.sw2[5] = ~(c1.face_select | c2.face_select);
        s.sw2[4] = 1'b1;
        s.sw2[3] = ~c2.face_a;
        s.sw2[2] = ~c2.dpad_down;
        s.sw2[1] = ~c2.dpad_up;
        s.sw2[0] = ~c2.dpad_left;
        return s;
    endfunction

    // 0xf widens to 0xff
    function automatic logic [7:0] widen(input logic [3:0] c);
        return 8'(c) * 8'd17;
    endfunction

    always @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            m_set <= '0;
            m_sw  <= '1;
            m_dl  <= 1'b0;
            m_div <= 3'd0;
            m_dt  <= '0;
            m_rom <= 32'd0;
        end else begin
            if (bridge.wr && bridge.addr == `BRIDGE_ADDR_PLAYERS)
                m_set.players <= bridge.data[1:0];
            if (bridge.wr && bridge.addr == `BRIDGE_ADDR_FIRST_BONUS)
                m_set.first_bonus <= bridge.data[1:0];
            if (bridge.wr && bridge.addr == `BRIDGE_ADDR_NEXT_BONUS)
                m_set.next_bonus <= bridge.data[1:0];
            if (bridge.wr && bridge.addr == `BRIDGE_ADDR_DIFFICULTY)
                m_set.difficulty <= bridge.data[1:0];
            m_sw <= map_keys(cont1, cont2);
            // request beats allcomplete
            m_dl  <= dataslot_requestwrite | (m_dl & ~dataslot_allcomplete);
            m_div <= m_div + 3'd1;
            if (m_div >= `POLL_WRITE_FROM) begin
                m_dt <= '{addr: `DT_SAVE_SIZE_ADDR, data: `SAVE_SIZE_BYTES, wren: 1'b1};
            end else begin
                m_dt.addr <= `DT_ROM_SIZE_ADDR;
                m_dt.wren <= 1'b0;
            end
            if (m_div == `POLL_SAMPLE_AT)
                m_rom <= datatable_q;
        end
    end

    // video model advances on the cycle after a pix rise
    always @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            m_pix_prev  <= 1'b0;
            m_en        <= 1'b0;
            m_hs_prev   <= 1'b1;
            m_vs_prev   <= 1'b1;
            m_vid       <= '0;
            m_rgb_valid <= 1'b0;
            for (vk = 0; vk < `HBLANK_DELAY; vk++)
                m_hbl[vk] <= 1'b0;
        end else begin
            m_pix_prev <= game.pix;
            m_en       <= game.pix & ~m_pix_prev;
            if (m_en) begin
                // m_hbl[0] is the newest sample
                for (vk = `HBLANK_DELAY - 1; vk > 0; vk--)
                    m_hbl[vk] <= m_hbl[vk - 1];
                m_hbl[0] <= game.hblank;
                m_vid.de <= ~m_hbl[`HBLANK_DELAY - 1] & ~game.vblank;
                if (!m_hbl[`HBLANK_DELAY - 1] && !game.vblank) begin
                    m_vid.rgb   <= {widen(game.r), widen(game.g), widen(game.b)};
                    m_rgb_valid <= 1'b1;
                end
                m_vid.hs  <= m_hs_prev & ~game.hs_n;
                m_vid.vs  <= m_vs_prev & ~game.vs_n;
                m_hs_prev <= game.hs_n;
                m_vs_prev <= game.vs_n;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        stop_on_error();
    endtask

    task automatic check_settings(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Mismatch in %s: dip_switches expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_switches(input string name, input game_switches_t exp,
                                  input game_switches_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: switches expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_dt(input string name, input dt_port_t exp, input dt_port_t act,
                            input logic [31:0] exp_size, input logic [31:0] act_size);
        if (act !== exp || act_size !== exp_size) begin
            $display("Mismatch in %s: datatable/size expected %h/%h, actual %h/%h",
                     name, exp, exp_size, act, act_size);
            stop_on_error();
        end
    endtask

    task automatic check_reset_gate(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: core_reset_n expected %b, actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_video(input string name, input scaler_video_t exp,
                               input scaler_video_t act, input logic rgb_known);
        scaler_video_t a;
        a = act;
        // rgb has no reset value until the first visible pixel
        if (!rgb_known)
            a.rgb = exp.rgb;
        if (a !== exp) begin
            $display("Mismatch in %s: scaler expected %h, actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    // outputs are stable half a period after the drive edge
    task automatic check_cycle();
        @(negedge clk_74a);
        check_settings(test_name, dip_from(m_set), dip_switches);
        check_switches(test_name, m_sw, switches);
        check_dt(test_name, m_dt, datatable, m_rom, rom_file_size);
        check_reset_gate(test_name, reset_n & ~m_dl, core_reset_n);
        check_video(test_name, m_vid, scaler, m_rgb_valid);
        if (scaler.de)
            vis_count++;
    endtask

    task automatic wait_reset_gate(input logic value, input int limit);
        int n;
        n = 0;
        while (core_reset_n !== value && n < limit) begin
            @(posedge clk_74a);
            check_cycle();
            n++;
        end
        if (core_reset_n !== value)
            report_failure("core_reset_n never reached the expected level");
    endtask

    task automatic wait_write_window(input int limit);
        int n;
        n = 0;
        while (datatable.wren !== 1'b1 && n < limit) begin
            @(posedge clk_74a);
            check_cycle();
            n++;
        end
        if (datatable.wren !== 1'b1)
            report_failure("poller never entered its write window");
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        game_video_t gv;
        int          hold;
        int          i;

        lcg_state             = 32'd18293;
        vis_count             = 0;
        test_name             = "reset";
        pll_core_locked       = 1'b0;
        bridge                = '0;
        reset_n               = 1'b1;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        datatable_q           = 32'd0;
        cont1                 = '0;
        cont2                 = '0;
        game                  = '0;
        game.hs_n             = 1'b1;
        game.vs_n             = 1'b1;
        repeat (4) @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        check_cycle();

        // about a third of the writes hit a setting
        test_name = "bridge_settings";
        for (i = 0; i < 150; i++) begin
            @(posedge clk_74a);
            r = next_rand();
            bridge.wr   <= r[31];
            bridge.data <= next_rand();
            if (r[23:16] < 8'd85) begin
                case (r[15:14])
                    2'd0:    bridge.addr <= `BRIDGE_ADDR_PLAYERS;
                    2'd1:    bridge.addr <= `BRIDGE_ADDR_FIRST_BONUS;
                    2'd2:    bridge.addr <= `BRIDGE_ADDR_NEXT_BONUS;
                    default: bridge.addr <= `BRIDGE_ADDR_DIFFICULTY;
                endcase
            end else begin
                bridge.addr <= next_rand();
            end
            check_cycle();
        end

        test_name = "controls";
        for (i = 0; i < 60; i++) begin
            @(posedge clk_74a);
            bridge.wr <= 1'b0;
            r = next_rand();
            cont1 <= cont_key_t'(r[31:16]);
            r = next_rand();
            cont2 <= cont_key_t'(r[31:16]);
            check_cycle();
        end

        test_name = "download_gate";
        for (i = 0; i < 100; i++) begin
            @(posedge clk_74a);
            r = next_rand();
            dataslot_requestwrite <= (r[31:29] == 3'd0);
            dataslot_allcomplete  <= (r[28:27] == 2'd0);
            reset_n               <= (r[26:24] != 3'd0);
            check_cycle();
        end
        // clear the flag and then raise both strobes at once
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        dataslot_allcomplete  <= 1'b1;
        reset_n               <= 1'b1;
        check_cycle();
        @(posedge clk_74a);
        dataslot_allcomplete <= 1'b0;
        check_cycle();
        wait_reset_gate(1'b1, 4);
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b1;
        dataslot_allcomplete  <= 1'b1;
        check_cycle();
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        dataslot_allcomplete  <= 1'b0;
        check_cycle();
        wait_reset_gate(1'b0, 4);

        // align to the write window and change q every 8 cycles
        test_name = "datatable_poll";
        wait_write_window(16);
        for (i = 0; i < 64; i++) begin
            @(posedge clk_74a);
            if (i % 8 == 0)
                datatable_q <= next_rand();
            check_cycle();
        end

        test_name = "video";
        gv   = game;
        hold = 1;
        for (i = 0; i < 800; i++) begin
            @(posedge clk_74a);
            r = next_rand();
            hold--;
            if (hold == 0) begin
                gv.pix = ~gv.pix;
                hold   = (r[9:8] == 2'd0) ? 3 : int'(r[9:8]);
            end
            gv.r = r[31:28];
            gv.g = r[27:24];
            gv.b = r[23:20];
            if (r[19:17] == 3'd0)
                gv.hs_n = ~gv.hs_n;
            if (r[16:14] == 3'd0)
                gv.vs_n = ~gv.vs_n;
            if (r[13:11] == 3'd0)
                gv.hblank = ~gv.hblank;
            if (r[7:4] == 4'd0)
                gv.vblank = ~gv.vblank;
            game <= gv;
            check_cycle();
        end

        if (vis_count == 0) begin
            report_failure("no visible pixel was produced by the video stream");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== src/core_top.sv ====
//////////////////////////////////////////////////////////////////////
// glue top for one arcade core, single clock domain clk_74a
// game core sits outside, its video comes in on game
// pll_core_locked is the asynchronous, active-low reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_top (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,

    // host bridge and data slots
    input  core_pkg::bridge_wr_t      bridge,
    input  logic                      reset_n,
    input  logic                      dataslot_requestwrite,
    input  logic                      dataslot_allcomplete,
    input  logic [31:0]               datatable_q,
    output core_pkg::dt_port_t        datatable,
    output logic [31:0]               rom_file_size,

    // controllers
    input  core_pkg::cont_key_t       cont1,
    input  core_pkg::cont_key_t       cont2,

    // towards the game
    output logic [7:0]                dip_switches,
    output core_pkg::game_switches_t  switches,
    output logic                      core_reset_n,

    // video
    input  core_pkg::game_video_t     game,
    output core_pkg::scaler_video_t   scaler
);

    // operator settings
    settings_regs u_settings_regs (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .bridge          (bridge),
        .dip_switches    (dip_switches)
    );

    // controls
    input_mapper u_input_mapper (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .cont1           (cont1),
        .cont2           (cont2),
        .switches        (switches)
    );

    // download gate and data table
    dataslot_control u_dataslot_control (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .reset_n               (reset_n),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .datatable_q           (datatable_q),
        .datatable             (datatable),
        .rom_file_size         (rom_file_size),
        .core_reset_n          (core_reset_n)
    );

    // scaler video
    video_formatter u_video_formatter (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .game            (game),
        .scaler          (scaler)
    );

endmodule

// ==== src/video_formatter.sv ====
//////////////////////////////////////////////////////////////////////
// game video to scaler video, everything advances on pixel enable
// pixel enable follows a rising edge of pix by one cycle
// rgb holds its last visible value while de is low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_params.svh"

module video_formatter (
    input  logic                     clk_74a,
    input  logic                     pll_core_locked,
    input  core_pkg::game_video_t    game,
    output core_pkg::scaler_video_t  scaler
);

    import core_pkg::*;

    logic                      pix_q;
    logic                      pix_en;
    logic [`HBLANK_DELAY-1:0]  hbl_sr;
    logic                      hbl_dly;
    logic                      active;
    logic                      hs_n_q;
    logic                      vs_n_q;
    logic                      de_q;
    logic                      hs_q;
    logic                      vs_q;
    logic [23:0]               rgb_q;

    //////////////////////////////////////////////////////////////////////
    // pixel enable
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            pix_q  <= 1'b0;
            pix_en <= 1'b0;
        end else begin
            pix_q  <= game.pix;
            // one cycle wide
            pix_en <= game.pix & ~pix_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // blank delay and scaler word
    //////////////////////////////////////////////////////////////////////

    // oldest stage, hblank from HBLANK_DELAY enables back
    assign hbl_dly = hbl_sr[`HBLANK_DELAY-1];
    assign active  = ~(hbl_dly | game.vblank);

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hbl_sr <= '0;
            hs_n_q <= 1'b1;
            vs_n_q <= 1'b1;
            de_q   <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
        end else if (pix_en) begin
            hbl_sr <= {hbl_sr[`HBLANK_DELAY-2:0], game.hblank};
            de_q   <= active;
            // pulse on the falling edge of each sync
            hs_q   <= hs_n_q & ~game.hs_n;
            vs_q   <= vs_n_q & ~game.vs_n;
            hs_n_q <= game.hs_n;
            vs_n_q <= game.vs_n;
        end
    end

    // 4 to 8 bit by repeating the nibble
    always_ff @(posedge clk_74a) begin
        if (pix_en && active) begin
            rgb_q <= {{2{game.r}}, {2{game.g}}, {2{game.b}}};
        end
    end

    assign scaler.rgb = rgb_q;
    assign scaler.de  = de_q;
    assign scaler.hs  = hs_q;
    assign scaler.vs  = vs_q;

endmodule

// ==== src/dataslot_control.sv ====
//////////////////////////////////////////////////////////////////////
// download flag, gated game reset and the data-table poll loop
// dataslot strobes are single cycle, acknowledgement is fixed
// poll loop repeats every 8 cycles, read 5 and write 3
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_params.svh"

module dataslot_control (
    input  logic                 clk_74a,
    input  logic                 pll_core_locked,
    input  logic                 reset_n,
    input  logic                 dataslot_requestwrite,
    input  logic                 dataslot_allcomplete,
    input  logic [31:0]          datatable_q,
    output core_pkg::dt_port_t   datatable,
    output logic [31:0]          rom_file_size,
    output logic                 core_reset_n
);

    import core_pkg::*;

    logic        download_q;
    logic [2:0]  div_q;
    poll_phase_e phase;
    dt_port_t    dt_q;
    logic [31:0] rom_size_q;

    //////////////////////////////////////////////////////////////////////
    // download flag
    //////////////////////////////////////////////////////////////////////

    // request wins over allcomplete
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            download_q <= 1'b0;
        end else if (dataslot_requestwrite) begin
            download_q <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download_q <= 1'b0;
        end
    end

    // game held in reset for the whole download
    assign core_reset_n = reset_n & ~download_q;

    //////////////////////////////////////////////////////////////////////
    // data-table poller
    //////////////////////////////////////////////////////////////////////

    // upper part of the divider is the write window
    always_comb begin
        if (div_q >= `POLL_WRITE_FROM) begin
            phase = poll_write;
        end else begin
            phase = poll_read;
        end
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            div_q      <= 3'd0;
            dt_q       <= '0;
            rom_size_q <= 32'd0;
        end else begin
            // free running, wraps every 8
            div_q <= div_q + 3'd1;
            case (phase)
                poll_write: begin
                    // report the save area size
                    dt_q.wren <= 1'b1;
                    dt_q.addr <= `DT_SAVE_SIZE_ADDR;
                    dt_q.data <= `SAVE_SIZE_BYTES;
                end
                poll_read: begin
                    // data holds, only addr and wren move
                    dt_q.wren <= 1'b0;
                    dt_q.addr <= `DT_ROM_SIZE_ADDR;
                    // q has settled on the rom size word by now
                    if (div_q == `POLL_SAMPLE_AT) begin
                        rom_size_q <= datatable_q;
                    end
                end
                default: dt_q <= dt_q;
            endcase
        end
    end

    assign datatable     = dt_q;
    assign rom_file_size = rom_size_q;

endmodule

// ==== src/input_mapper.sv ====
//////////////////////////////////////////////////////////////////////
// maps two controllers onto the game's switch bytes
// outputs are active low and registered, one cycle behind the keys
// coin is shared, pause has no game input here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module input_mapper (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,
    input  core_pkg::cont_key_t       cont1,
    input  core_pkg::cont_key_t       cont2,
    output core_pkg::game_switches_t  switches
);

    import core_pkg::*;

    game_switches_t sw_next;
    game_switches_t sw_q;
    logic           coin;

    // either player's select drops a coin
    assign coin = cont1.face_select | cont2.face_select;

    // player 1 byte, start buttons of both players live here
    assign sw_next.sw1 = {
        1'b1,
        ~cont2.face_start,
        ~cont1.face_start,
        ~cont1.face_a,
        ~cont1.dpad_down,
        ~cont1.dpad_up,
        ~cont1.dpad_left,
        ~cont1.dpad_right
    };

    // player 2 byte
    // bit 4 is a spare input, held released
    assign sw_next.sw2 = {
        1'b1,
        1'b1,
        ~coin,
        1'b1,
        ~cont2.face_a,
        ~cont2.dpad_down,
        ~cont2.dpad_up,
        ~cont2.dpad_left
    };

    // all released out of reset
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            sw_q <= '1;
        end else begin
            sw_q <= sw_next;
        end
    end

    assign switches = sw_q;

endmodule

// ==== src/settings_regs.sv ====
//////////////////////////////////////////////////////////////////////
// operator settings written over the host bridge
// only data bits [1:0] of a write are kept
// dip byte is combinational from the registered settings
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_params.svh"

module settings_regs (
    input  logic                   clk_74a,
    input  logic                   pll_core_locked,
    input  core_pkg::bridge_wr_t   bridge,
    output logic [7:0]             dip_switches
);

    import core_pkg::*;

    core_settings_t settings_q;
    setting_sel_e   sel;
    logic           hit;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // full address match, anything else is ignored
    always_comb begin
        hit = 1'b1;
        sel = players;
        case (bridge.addr)
            `BRIDGE_ADDR_PLAYERS:     sel = players;
            `BRIDGE_ADDR_FIRST_BONUS: sel = first_bonus;
            `BRIDGE_ADDR_NEXT_BONUS:  sel = next_bonus;
            `BRIDGE_ADDR_DIFFICULTY:  sel = difficulty;
            default:                  hit = 1'b0;
        endcase
    end

    // one field per write
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            settings_q <= '0;
        end else if (bridge.wr && hit) begin
            case (sel)
                players:     settings_q.players     <= bridge.data[1:0];
                first_bonus: settings_q.first_bonus <= bridge.data[1:0];
                next_bonus:  settings_q.next_bonus  <= bridge.data[1:0];
                difficulty:  settings_q.difficulty  <= bridge.data[1:0];
                default:     settings_q             <= settings_q;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // dip byte packing
    //////////////////////////////////////////////////////////////////////

    // game wants each pair high bit first from bit 0 upward
    assign dip_switches = {
        settings_q.players[0],
        settings_q.players[1],
        settings_q.next_bonus[0],
        settings_q.next_bonus[1],
        settings_q.first_bonus[0],
        settings_q.first_bonus[1],
        settings_q.difficulty[0],
        settings_q.difficulty[1]
    };

endmodule

// ==== src/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types for the wrapper glue
// all structs are packed, msb field listed first
//////////////////////////////////////////////////////////////////////

package core_pkg;

    // operator setting selector, from bridge address decode
    typedef enum logic [1:0] {
        players,
        first_bonus,
        next_bonus,
        difficulty
    } setting_sel_e;

    // four 2-bit operator settings
    typedef struct packed {
        logic [1:0] players;
        logic [1:0] first_bonus;
        logic [1:0] next_bonus;
        logic [1:0] difficulty;
    } core_settings_t;

    // controller key bitmap, face_start is bit 15, dpad_up bit 0
    typedef struct packed {
        logic face_start;
        logic face_select;
        logic trig_r3;
        logic trig_l3;
        logic trig_r2;
        logic trig_l2;
        logic trig_r1;
        logic trig_l1;
        logic face_y;
        logic face_x;
        logic face_b;
        logic face_a;
        logic dpad_right;
        logic dpad_left;
        logic dpad_down;
        logic dpad_up;
    } cont_key_t;

    // game switch bytes, active low
    typedef struct packed {
        logic [7:0] sw1;
        logic [7:0] sw2;
    } game_switches_t;

    // host bridge write side
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        wr;
    } bridge_wr_t;

    // data-table port towards the host
    typedef struct packed {
        logic [9:0]  addr;
        logic [31:0] data;
        logic        wren;
    } dt_port_t;

    // poll loop phase
    typedef enum logic {
        poll_read,
        poll_write
    } poll_phase_e;

    // raw game video, syncs active low
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       hs_n;
        logic       vs_n;
        logic       hblank;
        logic       vblank;
        logic       pix;
    } game_video_t;

    // scaler video word
    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } scaler_video_t;

endpackage

// ==== include/core_params.svh ====
//////////////////////////////////////////////////////////////////////
// fixed addresses and sizes for the arcade wrapper glue
// bridge addresses are full 32-bit matches, no partial decode
// data-table words are the host's 10-bit slot table indices
//////////////////////////////////////////////////////////////////////

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// operator setting registers on the host bridge
`define BRIDGE_ADDR_PLAYERS     32'h8000_0000
`define BRIDGE_ADDR_FIRST_BONUS 32'h9000_0000
`define BRIDGE_ADDR_NEXT_BONUS  32'h1000_0000
`define BRIDGE_ADDR_DIFFICULTY  32'h2000_0000

// data-table words
// rom slot size, read side
`define DT_ROM_SIZE_ADDR        10'd1
// save slot size, write side
`define DT_SAVE_SIZE_ADDR       10'd3

// save area reported back to the host, in bytes
`define SAVE_SIZE_BYTES         32'd65536

// poll divider points, 3-bit divider
`define POLL_WRITE_FROM         3'd5
`define POLL_SAMPLE_AT          3'd4

// hblank delay in pixel enables
`define HBLANK_DELAY            9

`endif
